/* sim.f */
+incdir+rtl
+incdir+tb
rtl/harness_pkg.sv
rtl/periph_bus_if.sv
rtl/bus_decoder.sv
rtl/sys_ram.sv
rtl/io_regs.sv
rtl/counter_block.sv
rtl/read_mux.sv
rtl/harness_top.sv
tb/harness_tb.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = harness_tb
FILELIST  = sim.f
OBJDIR    = obj_dir
LOG       = sim.log
PASS_MSG  = Regression passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJDIR) -f $(FILELIST)

run: compile
	./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "^$(PASS_MSG)$$" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)

/* tb/harness_tests.svh */
`ifndef HARNESS_TESTS_SVH
`define HARNESS_TESTS_SVH

// --------------------
// memory and simple registers
// --------------------
task automatic ram_readback();
	harness_pkg::bus_adr_t  adr_list [16];
	harness_pkg::bus_data_t data_list [16];
	harness_pkg::bus_data_t d;
	start_test("ram");
	for (int i = 0; i < 16; i++) begin
		adr_list[i]  = {4'h0, i[3:0], random_byte()};   // one address per 256-byte page
		data_list[i] = random_byte();
		write_byte(adr_list[i], data_list[i]);
	end
	for (int i = 0; i < 16; i++) begin
		read_byte(adr_list[i], d);
		expect_byte($sformatf("ram[%h]", adr_list[i]), data_list[i], d);
	end
	read_byte(16'h8000, d);
	expect_byte("unmapped 8000", 8'hff, d);
	read_byte(`HARNESS_CTR_BASE + 16'd8, d);   // first slot past the last counter
	expect_byte("unmapped counter slot", 8'hff, d);
	finish_test();
endtask

task automatic led_switch_access();
	harness_pkg::bus_data_t d0;
	harness_pkg::bus_data_t d1;
	harness_pkg::bus_data_t d;
	logic [15:0]            sw_val;
	start_test("led and switch");
	d0 = random_byte();
	d1 = random_byte();
	write_byte(`HARNESS_LED_BASE, d0);
	write_byte(`HARNESS_LED_BASE + 16'd1, d1);
	@(negedge cpuclk);
	expect_byte("led port low", d0, led[7:0]);
	expect_byte("led port high", d1, led[15:8]);
	read_byte(`HARNESS_LED_BASE, d);
	expect_byte("led read low", d0, d);
	read_byte(`HARNESS_LED_BASE + 16'd1, d);
	expect_byte("led read high", d1, d);
	sw_val = {random_byte(), random_byte()};
	@(posedge cpuclk);
	sw <= sw_val;
	read_byte(`HARNESS_SW_BASE, d);
	expect_byte("switch low", sw_val[7:0], d);
	read_byte(`HARNESS_SW_BASE + 16'd1, d);
	expect_byte("switch high", sw_val[15:8], d);
	finish_test();
endtask

task automatic write_atom(input harness_pkg::atom_t v);
	for (int k = 0; k < 4; k++)
		write_byte(`HARNESS_ATOM_BASE + 16'(k), v[8*k +: 8]);
endtask

task automatic atom_register_access();
	harness_pkg::atom_t     v;
	harness_pkg::bus_data_t d;
	start_test("atomic load");
	v = {random_byte(), random_byte(), random_byte(), random_byte()};
	write_atom(v);
	for (int k = 0; k < 4; k++) begin
		read_byte(`HARNESS_ATOM_BASE + 16'(k), d);
		expect_byte($sformatf("atom byte %0d", k), v[8*k +: 8], d);
	end
	finish_test();
endtask

// --------------------
// counters
// --------------------
// compares the three count bytes of one counter with a 20-bit value
task automatic check_count(input int ctr, input harness_pkg::atom_t v);
	harness_pkg::bus_adr_t  base;
	harness_pkg::bus_data_t d;
	base = `HARNESS_CTR_BASE + 16'(4 * ctr);
	read_byte(base + 16'd1, d);
	expect_byte($sformatf("counter %0d bits 7:0", ctr), v[7:0], d);
	read_byte(base + 16'd2, d);
	expect_byte($sformatf("counter %0d bits 15:8", ctr), v[15:8], d);
	read_byte(base + 16'd3, d);
	expect_byte($sformatf("counter %0d bits 19:16", ctr), {4'h0, v[19:16]}, d);
endtask

task automatic counter_load_run();
	harness_pkg::atom_t     v;
	harness_pkg::atom_t     stopped;
	harness_pkg::bus_data_t d;
	harness_pkg::bus_data_t first;
	start_test("counter");
	v = {random_byte(), random_byte(), random_byte(), random_byte()};
	write_atom(v);
	write_byte(`HARNESS_CTR_BASE, 8'h00);
	write_byte(`HARNESS_CTR_BASE + 16'd1, random_byte());   // data byte is ignored by the load
	read_byte(`HARNESS_CTR_BASE, d);
	expect_byte("counter 0 control", 8'h00, d);
	check_count(0, v);

	write_byte(`HARNESS_CTR_BASE, 8'h01);
	read_byte(`HARNESS_CTR_BASE + 16'd1, first);
	idle_cycles(300);
	read_byte(`HARNESS_CTR_BASE + 16'd1, d);
	checks++;
	assert (d !== first) else begin
		$display("%s: counter 0 low byte stayed at %h while running", test_name, d);
		errors++;
	end

	// stop counter 0 and give it a fresh known count
	write_byte(`HARNESS_CTR_BASE, 8'h00);
	stopped = {random_byte(), random_byte(), random_byte(), random_byte()};
	write_atom(stopped);
	write_byte(`HARNESS_CTR_BASE + 16'd1, 8'h00);

	v = {random_byte(), random_byte(), random_byte(), random_byte()};
	write_atom(v);
	write_byte(`HARNESS_CTR_BASE + 16'd5, 8'h00);
	check_count(1, v);
	check_count(0, stopped);
	finish_test();
endtask

// --------------------
// Port A and reset
// --------------------
task automatic port_a_masks();
	harness_pkg::bus_data_t expected;
	harness_pkg::bus_data_t m;
	harness_pkg::bus_data_t d;
	harness_pkg::bus_data_t pin;
	start_test("port a");
	expected = 8'h00;
	m = random_byte();
	write_byte(`HARNESS_PORTA_BASE, m);
	expected = expected | m;
	read_byte(`HARNESS_PORTA_BASE, d);
	expect_byte("set mask read", expected, d);
	expect_byte("set mask port", expected, pa_out);
	m = random_byte();
	write_byte(`HARNESS_PORTA_BASE + 16'd1, m);
	expected = expected & ~m;
	read_byte(`HARNESS_PORTA_BASE, d);
	expect_byte("clear mask read", expected, d);
	expect_byte("clear mask port", expected, pa_out);

	write_byte(`HARNESS_PORTA_BASE + 16'd1, 8'hff);
	write_run(`HARNESS_PORTA_BASE, 8'h01, 8'h02, 8'h04);   // only the first write of the run sets
	read_byte(`HARNESS_PORTA_BASE, d);
	expect_byte("write run read", 8'h01, d);
	expect_byte("write run port", 8'h01, pa_out);

	pin = random_byte();
	@(posedge cpuclk);
	pa_in <= pin;
	read_byte(`HARNESS_PORTA_BASE + 16'd1, d);
	expect_byte("pa_in read", pin, d);
	finish_test();
endtask

task automatic reset_recovery();
	harness_pkg::bus_data_t d;
	start_test("reset");
	write_byte(`HARNESS_LED_BASE, 8'ha5);
	write_byte(`HARNESS_LED_BASE + 16'd1, 8'h5a);
	write_byte(`HARNESS_PORTA_BASE, 8'h3c);
	write_byte(`HARNESS_CTR_BASE, 8'h01);
	idle_cycles(4);
	@(posedge cpuclk);
	f_reset <= 1'b1;
	idle_cycles(8);
	f_reset <= 1'b0;
	idle_cycles(2);
	@(negedge cpuclk);
	expect_byte("led low after reset", 8'h00, led[7:0]);
	expect_byte("led high after reset", 8'h00, led[15:8]);
	expect_byte("pa_out after reset", 8'h00, pa_out);
	expect_byte("rdata_valid after reset", 8'h00, {7'b0, rdata_valid});
	for (int k = 0; k < 4; k++) begin
		read_byte(`HARNESS_CTR_BASE + 16'(k), d);
		expect_byte($sformatf("counter 0 offset %0d", k), 8'h00, d);
	end
	finish_test();
endtask

`endif

/* tb/harness_tb.sv */
`timescale 1ns/1ns
`include "harness_defines.svh"

module harness_tb;

	localparam int read_timeout = 20;   // cycles allowed for rdata_valid to show up

	logic                   cpuclk = 1'b0;
	logic                   f_reset;
	harness_pkg::bus_adr_t  adr;
	harness_pkg::bus_data_t wdata;
	logic                   wr;
	logic                   rd;
	harness_pkg::bus_data_t rdata;
	logic                   rdata_valid;
	logic [15:0]            led;
	logic [15:0]            sw;
	logic [7:0]             pa_in;
	logic [7:0]             pa_out;

	integer seed = 77230;
	int     checks = 0;
	int     errors = 0;
	int     tests_run = 0;
	int     test_errors_start = 0;
	string  test_name = "";

	harness_top harness_top_inst (
		.cpuclk     (cpuclk),
		.f_reset    (f_reset),
		.adr        (adr),
		.wdata      (wdata),
		.wr         (wr),
		.rd         (rd),
		.rdata      (rdata),
		.rdata_valid(rdata_valid),
		.led        (led),
		.sw         (sw),
		.pa_in      (pa_in),
		.pa_out     (pa_out)
	);

	always #4 cpuclk = ~cpuclk;

	// --------------------
	// bus access
	// --------------------
	task automatic write_byte(input harness_pkg::bus_adr_t a, input harness_pkg::bus_data_t d);
		@(posedge cpuclk);
		adr   <= a;
		wdata <= d;
		wr    <= 1'b1;
		@(posedge cpuclk);   // the write lands on this edge
		wr    <= 1'b0;
	endtask

	// three back-to-back writes to one address, no idle cycle in between
	task automatic write_run(input harness_pkg::bus_adr_t a, input harness_pkg::bus_data_t d0,
			input harness_pkg::bus_data_t d1, input harness_pkg::bus_data_t d2);
		@(posedge cpuclk);
		adr   <= a;
		wdata <= d0;
		wr    <= 1'b1;
		@(posedge cpuclk);
		wdata <= d1;
		@(posedge cpuclk);
		wdata <= d2;
		@(posedge cpuclk);
		wr    <= 1'b0;
	endtask

	task automatic read_byte(input harness_pkg::bus_adr_t a, output harness_pkg::bus_data_t d);
		int wait_cycles;
		wait_cycles = 0;
		@(posedge cpuclk);
		adr <= a;
		rd  <= 1'b1;
		@(posedge cpuclk);
		rd  <= 1'b0;
		@(negedge cpuclk);
		while (!rdata_valid && wait_cycles < read_timeout) begin
			@(negedge cpuclk);
			wait_cycles++;
		end
		if (rdata_valid) begin
			d = rdata;
		end else begin
			$display("%s: no rdata_valid within %0d cycles of the read at %h",
				test_name, read_timeout, a);
			errors++;
			d = 'x;
		end
	endtask

	task automatic idle_cycles(input int n);
		repeat (n) @(posedge cpuclk);
	endtask

	function automatic harness_pkg::bus_data_t random_byte();
		logic [31:0] r;
		r = $random(seed);
		return r[7:0];
	endfunction

	// --------------------
	// checking
	// --------------------
	task automatic expect_byte(input string what, input harness_pkg::bus_data_t expected,
			input harness_pkg::bus_data_t actual);
		checks++;
		assert (actual === expected) else begin
			$display("** Error %s: %s expected %h, actual %h", test_name, what, expected, actual);
			errors++;
		end
	endtask

	task automatic start_test(input string name);
		test_name         = name;
		test_errors_start = errors;
	endtask

	task automatic finish_test();
		tests_run++;
		$display("%-18s %s, %0d errors", test_name,
			(errors == test_errors_start) ? "ok" : "failed", errors - test_errors_start);
	endtask

	`include "harness_tests.svh"

	initial begin
		f_reset = 1'b1;
		adr     = '0;
		wdata   = '0;
		wr      = 1'b0;
		rd      = 1'b0;
		sw      = '0;
		pa_in   = '0;
		repeat (8) @(posedge cpuclk);
		f_reset <= 1'b0;
		idle_cycles(2);   // decoder stays idle one cycle past reset

		ram_readback();
		led_switch_access();
		atom_register_access();
		counter_load_run();
		port_a_masks();
		reset_recovery();

		$display("%0d tests, %0d checks, %0d errors", tests_run, checks, errors);
		if (errors == 0)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	end

endmodule

/* rtl/harness_top.sv */
`timescale 1ns/1ns
`include "harness_defines.svh"

module harness_top (
	input  logic                   cpuclk,
	input  logic                   f_reset,
	input  harness_pkg::bus_adr_t  adr,
	input  harness_pkg::bus_data_t wdata,
	input  logic                   wr,
	input  logic                   rd,
	output harness_pkg::bus_data_t rdata,
	output logic                   rdata_valid,
	output logic [15:0]            led,
	input  logic [15:0]            sw,
	input  logic [7:0]             pa_in,
	output logic [7:0]             pa_out
);

	periph_bus_if bus ();

	harness_pkg::bus_data_t ram_rdata;
	harness_pkg::bus_data_t io_rdata;
	harness_pkg::bus_data_t ctr_rdata [`HARNESS_NUM_COUNTERS];
	harness_pkg::atom_t     atom_value;

	bus_decoder bus_decoder_inst (
		.cpuclk (cpuclk),
		.f_reset(f_reset),
		.adr    (adr),
		.wdata  (wdata),
		.wr     (wr),
		.rd     (rd),
		.bus    (bus.ctrl)
	);

	sys_ram sys_ram_inst (
		.cpuclk   (cpuclk),
		.bus      (bus.periph),
		.ram_rdata(ram_rdata)
	);

	io_regs io_regs_inst (
		.cpuclk    (cpuclk),
		.f_reset   (f_reset),
		.bus       (bus.periph),
		.sw        (sw),
		.pa_in     (pa_in),
		.led       (led),
		.pa_out    (pa_out),
		.atom_value(atom_value),
		.io_rdata  (io_rdata)
	);

	// one block per counter slot, all loaded from the atomic register
	for (genvar i = 0; i < `HARNESS_NUM_COUNTERS; i++) begin : g_counter
		counter_block #(
			.index(i)
		) counter_block_inst (
			.cpuclk    (cpuclk),
			.f_reset   (f_reset),
			.bus       (bus.periph),
			.atom_value(atom_value),
			.ctr_rdata (ctr_rdata[i])
		);
	end

	read_mux read_mux_inst (
		.cpuclk     (cpuclk),
		.f_reset    (f_reset),
		.bus        (bus.periph),
		.ram_rdata  (ram_rdata),
		.io_rdata   (io_rdata),
		.ctr_rdata  (ctr_rdata),
		.rdata      (rdata),
		.rdata_valid(rdata_valid)
	);

endmodule

/* rtl/read_mux.sv */
`timescale 1ns/1ns
`include "harness_defines.svh"

module read_mux (
	input  logic                   cpuclk,
	input  logic                   f_reset,
	periph_bus_if.periph           bus,
	input  harness_pkg::bus_data_t ram_rdata,
	input  harness_pkg::bus_data_t io_rdata,
	input  harness_pkg::bus_data_t ctr_rdata [`HARNESS_NUM_COUNTERS],
	output harness_pkg::bus_data_t rdata,
	output logic                   rdata_valid
);

	harness_pkg::bus_sel_e sel_r;
	logic [2:0]            idx_r;
	logic                  rd_r;

	// hold the select for the cycle in which the targets present their byte
	always_ff @(posedge cpuclk) begin
		if (f_reset) begin
			sel_r <= harness_pkg::sel_none;
			rd_r  <= 1'b0;
		end else begin
			sel_r <= bus.sel;
			rd_r  <= bus.rd;
		end
	end

	always_ff @(posedge cpuclk) begin
		idx_r <= bus.ctr_index;
	end

	always_comb begin
		rdata = 8'hff;
		case (sel_r)
			harness_pkg::sel_ram:
				rdata = ram_rdata;
			harness_pkg::sel_led0, harness_pkg::sel_led1, harness_pkg::sel_sw0,
			harness_pkg::sel_sw1, harness_pkg::sel_atom, harness_pkg::sel_porta:
				rdata = io_rdata;
			harness_pkg::sel_counter:
				for (int i = 0; i < `HARNESS_NUM_COUNTERS; i++) begin
					if (idx_r == 3'(i))
						rdata = ctr_rdata[i];
				end
			default:
				rdata = 8'hff;
		endcase
	end

	assign rdata_valid = rd_r;

endmodule

/* rtl/counter_block.sv */
`timescale 1ns/1ns
`include "harness_defines.svh"

module counter_block #(
	parameter int index = 0
) (
	input  logic                   cpuclk,
	input  logic                   f_reset,
	periph_bus_if.periph           bus,
	input  harness_pkg::atom_t     atom_value,
	output harness_pkg::bus_data_t ctr_rdata
);

	logic                hit;
	logic                run;
	logic                load;
	harness_pkg::count_t count;

	// the decoder has already picked the counter window
	assign hit  = bus.sel == harness_pkg::sel_counter && bus.ctr_index == 3'(index);
	assign load = hit && bus.wr && bus.reg_adr == 2'd1;

	// --------------------
	// control and count
	// --------------------
	always_ff @(posedge cpuclk) begin
		if (f_reset) begin
			run <= 1'b0;
		end else if (hit && bus.wr && bus.reg_adr == 2'd0) begin
			run <= bus.wdata[0];
		end
	end

	always_ff @(posedge cpuclk) begin
		if (f_reset)
			count <= '0;
		else if (load)
			count <= atom_value[`HARNESS_COUNTER_WIDTH-1:0];   // the load beats an increment
		else if (run)
			count <= count + 1'b1;    // wraps at the top of the counter width
	end

	// readback, one cycle after the address like the other targets
	always_ff @(posedge cpuclk) begin
		case (bus.reg_adr)
			2'd0:    ctr_rdata <= {7'b0, run};
			2'd1:    ctr_rdata <= count[7:0];
			2'd2:    ctr_rdata <= count[15:8];
			default: ctr_rdata <= 8'(count[`HARNESS_COUNTER_WIDTH-1:16]);
		endcase
	end

endmodule

/* rtl/io_regs.sv */
`timescale 1ns/1ns

module io_regs (
	input  logic                   cpuclk,
	input  logic                   f_reset,
	periph_bus_if.periph           bus,
	input  logic [15:0]            sw,
	input  logic [7:0]             pa_in,
	output logic [15:0]            led,
	output logic [7:0]             pa_out,
	output harness_pkg::atom_t     atom_value,
	output harness_pkg::bus_data_t io_rdata
);

	logic [15:0]            sw_r;
	logic                   pa_wr;
	logic                   pa_wr_r;
	logic                   pa_off_r;
	logic                   pa_trigger;
	harness_pkg::bus_data_t pa_set_mask;
	harness_pkg::bus_data_t pa_clr_mask;

	// --------------------
	// LEDs and atomic load
	// --------------------
	always_ff @(posedge cpuclk) begin
		if (f_reset) begin
			led <= '0;
		end else if (bus.wr) begin
			if (bus.sel == harness_pkg::sel_led0)
				led[7:0] <= bus.wdata;
			if (bus.sel == harness_pkg::sel_led1)
				led[15:8] <= bus.wdata;
		end
	end

	always_ff @(posedge cpuclk) begin
		sw_r <= sw;
		if (bus.wr && bus.sel == harness_pkg::sel_atom)
			atom_value[{bus.reg_adr, 3'b000} +: 8] <= bus.wdata;
	end

	// --------------------
	// Port A
	// --------------------
	assign pa_wr = bus.wr && bus.sel == harness_pkg::sel_porta;

	// only the first write of a run to the same register acts
	assign pa_trigger = pa_wr && !(pa_wr_r && pa_off_r == bus.reg_adr[0]);

	always_ff @(posedge cpuclk) begin
		if (f_reset) begin
			pa_wr_r     <= 1'b0;
			pa_off_r    <= 1'b0;
			pa_set_mask <= '0;
			pa_clr_mask <= '0;
			pa_out      <= '0;
		end else begin
			pa_wr_r     <= pa_wr;
			pa_off_r    <= bus.reg_adr[0];
			pa_set_mask <= (pa_trigger && !bus.reg_adr[0]) ? bus.wdata : '0;
			pa_clr_mask <= (pa_trigger && bus.reg_adr[0]) ? bus.wdata : '0;
			pa_out      <= (pa_out | pa_set_mask) & ~pa_clr_mask;   // masks land a cycle later
		end
	end

	// read byte lines up with the RAM output
	always_ff @(posedge cpuclk) begin
		case (bus.sel)
			harness_pkg::sel_led0:  io_rdata <= led[7:0];
			harness_pkg::sel_led1:  io_rdata <= led[15:8];
			harness_pkg::sel_sw0:   io_rdata <= sw_r[7:0];
			harness_pkg::sel_sw1:   io_rdata <= sw_r[15:8];
			harness_pkg::sel_atom:  io_rdata <= atom_value[{bus.reg_adr, 3'b000} +: 8];
			harness_pkg::sel_porta: io_rdata <= bus.reg_adr[0] ? pa_in : pa_out;
			default:                io_rdata <= 8'hff;
		endcase
	end

endmodule

/* rtl/sys_ram.sv */
`timescale 1ns/1ns
`include "harness_defines.svh"

module sys_ram (
	input  logic                   cpuclk,
	periph_bus_if.periph           bus,
	output harness_pkg::bus_data_t ram_rdata
);

	localparam int depth = 1 << `HARNESS_RAM_ADR_WIDTH;

	harness_pkg::bus_data_t mem [0:depth-1];

	logic ram_wr;

	assign ram_wr = bus.wr && bus.sel == harness_pkg::sel_ram;

	// single port, read data one cycle after the address
	always_ff @(posedge cpuclk) begin
		if (ram_wr)
			mem[bus.ram_adr] <= bus.wdata;
		ram_rdata <= mem[bus.ram_adr];
	end

endmodule

/* rtl/bus_decoder.sv */
`timescale 1ns/1ns
`include "harness_defines.svh"

module bus_decoder (
	input  logic                   cpuclk,
	input  logic                   f_reset,
	input  harness_pkg::bus_adr_t  adr,
	input  harness_pkg::bus_data_t wdata,
	input  logic                   wr,
	input  logic                   rd,
	periph_bus_if.ctrl             bus
);

	logic                  reset_done;
	logic                  bus_en;
	harness_pkg::bus_sel_e sel;

	// the bus stays idle for one more cycle after reset is released
	always_ff @(posedge cpuclk) begin
		if (f_reset)
			reset_done <= 1'b0;
		else
			reset_done <= 1'b1;
	end

	assign bus_en = reset_done && !f_reset;

	// --------------------
	// address table
	// --------------------
	always_comb begin
		sel = harness_pkg::sel_none;
		if (bus_en) begin
			if (adr[15:`HARNESS_RAM_ADR_WIDTH] == '0)
				sel = harness_pkg::sel_ram;          // 0x0000-0x0fff
			else if (adr == `HARNESS_LED_BASE)
				sel = harness_pkg::sel_led0;
			else if (adr == `HARNESS_LED_BASE + 16'd1)
				sel = harness_pkg::sel_led1;
			else if (adr == `HARNESS_SW_BASE)
				sel = harness_pkg::sel_sw0;
			else if (adr == `HARNESS_SW_BASE + 16'd1)
				sel = harness_pkg::sel_sw1;
			else if ((adr & 16'hfffc) == `HARNESS_ATOM_BASE)
				sel = harness_pkg::sel_atom;
			else if ((adr & 16'hffe0) == `HARNESS_CTR_BASE &&
					adr[4:2] < `HARNESS_NUM_COUNTERS)
				sel = harness_pkg::sel_counter;      // slots past the last counter stay unmapped
			else if ((adr & 16'hfffe) == `HARNESS_PORTA_BASE)
				sel = harness_pkg::sel_porta;
		end
	end

	assign bus.sel       = sel;
	assign bus.ctr_index = adr[4:2];
	assign bus.reg_adr   = adr[1:0];
	assign bus.ram_adr   = adr[`HARNESS_RAM_ADR_WIDTH-1:0];
	assign bus.wdata     = wdata;
	assign bus.wr        = wr && sel != harness_pkg::sel_none;
	assign bus.rd        = rd && bus_en;   // an unmapped read still completes and returns 0xff

endmodule

/* rtl/periph_bus_if.sv */
`timescale 1ns/1ns

interface periph_bus_if;

	harness_pkg::bus_sel_e  sel;
	logic [2:0]             ctr_index;   // counter slot taken from adr[4:2]
	harness_pkg::reg_adr_t  reg_adr;
	harness_pkg::ram_adr_t  ram_adr;
	harness_pkg::bus_data_t wdata;
	logic                   wr;
	logic                   rd;

	// driven by the decoder
	modport ctrl (
		output sel, ctr_index, reg_adr, ram_adr, wdata, wr, rd
	);

	// seen by every target and by the read mux
	modport periph (
		input sel, ctr_index, reg_adr, ram_adr, wdata, wr, rd
	);

endinterface

/* rtl/harness_pkg.sv */
`include "harness_defines.svh"

package harness_pkg;

	typedef logic [15:0] bus_adr_t;
	typedef logic [7:0] bus_data_t;
	typedef logic [1:0] reg_adr_t;   // byte offset inside a peripheral window
	typedef logic [`HARNESS_RAM_ADR_WIDTH-1:0] ram_adr_t;
	typedef logic [`HARNESS_COUNTER_WIDTH-1:0] count_t;
	typedef logic [31:0] atom_t;

	// target picked by the address decoder
	typedef enum logic [3:0] {
		sel_none, sel_ram, sel_led0, sel_led1, sel_sw0, sel_sw1,
		sel_atom, sel_counter, sel_porta
	} bus_sel_e;

endpackage

/* rtl/harness_defines.svh */
`ifndef HARNESS_DEFINES_SVH
`define HARNESS_DEFINES_SVH

// --------------------
// sizes
// --------------------
`define HARNESS_NUM_COUNTERS  2
`define HARNESS_COUNTER_WIDTH 20
`define HARNESS_RAM_ADR_WIDTH 12   // 4 KiB of system RAM

// --------------------
// peripheral map
// --------------------
`define HARNESS_LED_BASE      16'hff00
`define HARNESS_SW_BASE       16'hff02
`define HARNESS_ATOM_BASE     16'hff10
`define HARNESS_CTR_BASE      16'hff20   // four bytes per counter, up to eight slots
`define HARNESS_PORTA_BASE    16'hff40

`endif
